// ==== all.f ====
design/im2col_pkg.sv
design/im2col_param_unit.sv
design/im2col_txn_fifo.sv
design/im2col_channel_tracker.sv
design/im2col_dma_loader.sv
design/im2col_top.sv
dv/im2col_tb.sv

// ==== design/im2col_channel_tracker.sv ====
`timescale 1ns/1ps

module im2col_channel_tracker
  import im2col_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  ch_mask_t ch_mask_i,
  input  ch_mask_t dma_done_i,
  input  logic     claim_i,
  output ch_idx_t  free_ch_o,
  output logic     any_free_o,
  output logic     first_use_o,
  output logic     all_idle_o
);

  ch_mask_t busy_q;
  ch_mask_t used_q;     // Channel already loaded in this run
  ch_mask_t claim_set;

  // Lowest enabled channel that is not running
  always_comb begin
    free_ch_o  = '0;
    any_free_o = 1'b0;
    for (int i = CH_NUM - 1; i >= 0; i--) begin
      if (ch_mask_i[i] && !busy_q[i]) begin
        free_ch_o  = ch_idx_t'(i);
        any_free_o = 1'b1;
      end
    end
  end

  assign claim_set = claim_i ? (ch_mask_t'(1) << free_ch_o) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= '0;
      used_q <= '0;
    end else begin
      busy_q <= (busy_q & ~dma_done_i) | claim_set;
      if (start_i) begin
        used_q <= '0;  // Dimensionality rewritten each run
      end else begin
        used_q <= used_q | claim_set;
      end
    end
  end

  assign first_use_o = !used_q[free_ch_o];
  assign all_idle_o  = (busy_q == '0);

endmodule

// ==== design/im2col_dma_loader.sv ====
`timescale 1ns/1ps

module im2col_dma_loader
  import im2col_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                fifo_empty_i,
  input  dma_txn_t            txn_i,
  input  logic [STRIDE_W-1:0] stride_d1_i,
  input  logic                any_free_i,
  input  ch_idx_t             free_ch_i,
  input  logic                first_use_i,
  input  logic                bus_rvalid_i,
  output logic                fifo_pop_o,
  output logic                claim_o,
  output logic                bus_req_o,
  output word_t               bus_addr_o,
  output word_t               bus_wdata_o,
  output logic                idle_o
);

  load_state_e state_q, state_d;
  load_state_e next_wr;   // State after the current write
  logic        is_wr;
  logic        pending_q; // Request sent, waiting for rvalid
  ch_idx_t     ch_q;
  dma_reg_e    reg_off;
  word_t       wdata;

  // Register, value and successor of each write state
  always_comb begin
    reg_off = DIMENSIONALITY;
    wdata   = '0;
    next_wr = LD_POP;
    is_wr   = 1'b1;
    case (state_q)
      LD_DIM: begin
        reg_off = DIMENSIONALITY;
        wdata   = 32'd1;  // 2D transfers
        next_wr = LD_TOP_PAD;
      end
      LD_TOP_PAD: begin
        reg_off = TOP_PAD;
        wdata   = txn_i.zeros_top * ELEM_BYTES;
        next_wr = LD_BOTTOM_PAD;
      end
      LD_BOTTOM_PAD: begin
        reg_off = BOTTOM_PAD;
        wdata   = txn_i.zeros_bottom * ELEM_BYTES;
        next_wr = LD_LEFT_PAD;
      end
      LD_LEFT_PAD: begin
        reg_off = LEFT_PAD;
        wdata   = txn_i.zeros_left * ELEM_BYTES;
        next_wr = LD_RIGHT_PAD;
      end
      LD_RIGHT_PAD: begin
        reg_off = RIGHT_PAD;
        wdata   = txn_i.zeros_right * ELEM_BYTES;
        next_wr = LD_SRC_PTR;
      end
      LD_SRC_PTR: begin
        reg_off = SRC_PTR;
        wdata   = txn_i.in_ptr;
        next_wr = LD_DST_PTR;
      end
      LD_DST_PTR: begin
        reg_off = DST_PTR;
        wdata   = txn_i.out_ptr;
        next_wr = LD_INC_SRC_D1;
      end
      LD_INC_SRC_D1: begin
        reg_off = INC_SRC_D1;
        wdata   = word_t'(stride_d1_i) * ELEM_BYTES;
        next_wr = LD_INC_SRC_D2;
      end
      LD_INC_SRC_D2: begin
        reg_off = INC_SRC_D2;
        wdata   = txn_i.inc_src_d2 * ELEM_BYTES;
        next_wr = LD_INC_DST_D1;
      end
      LD_INC_DST_D1: begin
        reg_off = INC_DST_D1;
        wdata   = ELEM_BYTES;  // Output is dense
        next_wr = LD_INC_DST_D2;
      end
      LD_INC_DST_D2: begin
        reg_off = INC_DST_D2;
        wdata   = ELEM_BYTES;
        next_wr = LD_SIZE_D2;
      end
      LD_SIZE_D2: begin
        reg_off = SIZE_D2;
        wdata   = txn_i.size_d2 * ELEM_BYTES;
        next_wr = LD_SIZE_D1;
      end
      LD_SIZE_D1: begin
        reg_off = SIZE_D1;  // Last write, starts the channel
        wdata   = txn_i.size_d1 * ELEM_BYTES;
        next_wr = LD_POP;
      end
      default: is_wr = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      LD_IDLE:  if (!fifo_empty_i && any_free_i) state_d = LD_CLAIM;
      LD_CLAIM: state_d = first_use_i ? LD_DIM : LD_TOP_PAD;
      LD_POP:   state_d = LD_IDLE;
      default:  if (pending_q && bus_rvalid_i) state_d = next_wr;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= LD_IDLE;
      pending_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (bus_req_o) begin
        pending_q <= 1'b1;
      end else if (bus_rvalid_i) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (claim_o) ch_q <= free_ch_i;  // Same index the tracker marks busy
  end

  assign claim_o     = (state_q == LD_CLAIM);
  assign fifo_pop_o  = (state_q == LD_POP);
  assign idle_o      = (state_q == LD_IDLE);
  assign bus_req_o   = is_wr && !pending_q;  // One strobe per write
  assign bus_addr_o  = DMA_START_ADDR + word_t'(ch_q) * DMA_CH_SIZE + word_t'(reg_off);
  assign bus_wdata_o = wdata;

endmodule

// ==== design/im2col_param_unit.sv ====
`timescale 1ns/1ps

module im2col_param_unit
  import im2col_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic [DIM_W-1:0]    iw_i,
  input  logic [DIM_W-1:0]    ih_i,
  input  logic [DIM_W-1:0]    num_ch_i,
  input  logic [DIM_W-1:0]    fw_i,
  input  logic [DIM_W-1:0]    fh_i,
  input  logic [STRIDE_W-1:0] stride_d1_i,
  input  logic [STRIDE_W-1:0] stride_d2_i,
  input  logic [PAD_W-1:0]    pad_top_i,
  input  logic [PAD_W-1:0]    pad_bottom_i,
  input  logic [PAD_W-1:0]    pad_left_i,
  input  logic [PAD_W-1:0]    pad_right_i,
  input  logic [DIM_W-1:0]    n_patches_w_i,
  input  logic [DIM_W-1:0]    n_patches_h_i,
  input  word_t               src_ptr_i,
  input  word_t               dst_ptr_i,
  input  logic                fifo_full_i,
  output logic                push_o,
  output dma_txn_t            txn_o,
  output logic                last_pushed_o
);

  param_state_e state_q, state_d;

  logic [DIM_W-1:0] w_off_q, h_off_q, c_off_q;
  logic             last_elem;
  logic             last_pushed_q;

  word_t w_lim_q, h_lim_q;  // fw-1-w_off and fh-1-h_off
  word_t row_q, col_q;      // May be negative while inside the pad
  word_t index_q;
  word_t s1, s2;
  word_t patch_bytes;
  dma_txn_t txn_q;

  // Zeros needed before pos reaches the image edge, rounded up
  function automatic word_t zero_count(word_t pad, word_t pos, word_t stride);
    if (pos < pad) begin
      return (pad - pos + stride - 32'd1) / stride;
    end
    return '0;
  endfunction

  assign s1 = word_t'(stride_d1_i);
  assign s2 = word_t'(stride_d2_i);
  assign patch_bytes = word_t'(n_patches_h_i) * word_t'(n_patches_w_i) * ELEM_BYTES;

  assign last_elem = (w_off_q == fw_i - 1'b1) && (h_off_q == fh_i - 1'b1) &&
                     (c_off_q == num_ch_i - 1'b1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      P_IDLE:    if (start_i) state_d = P_LIMIT;
      P_LIMIT:   state_d = P_COORD;
      P_COORD:   state_d = P_ZEROS;
      P_ZEROS:   state_d = P_RUN1;
      P_RUN1:    state_d = P_RUN2;
      P_RUN2:    if (!fifo_full_i) state_d = P_PUSH;  // Hold on back-pressure
      P_PUSH:    state_d = P_ADVANCE;
      P_ADVANCE: state_d = last_elem ? P_IDLE : P_LIMIT;
      default:   state_d = P_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= P_IDLE;
      w_off_q       <= '0;
      h_off_q       <= '0;
      c_off_q       <= '0;
      last_pushed_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        w_off_q       <= '0;
        h_off_q       <= '0;
        c_off_q       <= '0;
        last_pushed_q <= 1'b0;
      end else if (state_q == P_ADVANCE) begin
        // w fastest, then h, then channel
        if (w_off_q == fw_i - 1'b1) begin
          w_off_q <= '0;
          if (h_off_q == fh_i - 1'b1) begin
            h_off_q <= '0;
            c_off_q <= c_off_q + 1'b1;
          end else begin
            h_off_q <= h_off_q + 1'b1;
          end
        end else begin
          w_off_q <= w_off_q + 1'b1;
        end
        if (last_elem) last_pushed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      P_IDLE: begin
        if (start_i) txn_q.out_ptr <= dst_ptr_i;
      end
      P_LIMIT: begin
        w_lim_q <= word_t'(fw_i) - 32'd1 - word_t'(w_off_q);
        h_lim_q <= word_t'(fh_i) - 32'd1 - word_t'(h_off_q);
      end
      P_COORD: begin
        row_q <= word_t'(h_off_q) - word_t'(pad_top_i);
        col_q <= word_t'(w_off_q) - word_t'(pad_left_i);
      end
      P_ZEROS: begin
        txn_q.zeros_top    <= zero_count(word_t'(pad_top_i), word_t'(h_off_q), s2);
        txn_q.zeros_left   <= zero_count(word_t'(pad_left_i), word_t'(w_off_q), s1);
        txn_q.zeros_bottom <= zero_count(word_t'(pad_bottom_i), h_lim_q, s2);
        txn_q.zeros_right  <= zero_count(word_t'(pad_right_i), w_lim_q, s1);
      end
      P_RUN1: begin
        txn_q.size_d1 <= word_t'(n_patches_w_i) - txn_q.zeros_left - txn_q.zeros_right;
        txn_q.size_d2 <= word_t'(n_patches_h_i) - txn_q.zeros_top - txn_q.zeros_bottom;
        index_q <= (word_t'(c_off_q) * word_t'(ih_i) + row_q + txn_q.zeros_top * s2)
                   * word_t'(iw_i) + col_q + txn_q.zeros_left * s1;
      end
      P_RUN2: begin
        txn_q.in_ptr     <= src_ptr_i + index_q * ELEM_BYTES;
        txn_q.inc_src_d2 <= s2 * word_t'(iw_i) - (txn_q.size_d1 - 32'd1) * s1;
      end
      P_ADVANCE: begin
        txn_q.out_ptr <= txn_q.out_ptr + patch_bytes;  // Next output column block
      end
      default: ;
    endcase
  end

  assign push_o        = (state_q == P_PUSH);
  assign txn_o         = txn_q;
  assign last_pushed_o = last_pushed_q;

endmodule

// ==== design/im2col_pkg.sv ====
package im2col_pkg;

  localparam int WORD_W   = 32;   // Bus address and data width
  localparam int DIM_W    = 16;
  localparam int STRIDE_W = 8;
  localparam int PAD_W    = 6;
  localparam int CH_NUM   = 4;    // DMA channels
  localparam int FIFO_DEPTH = 4;  // Descriptor slots

  typedef logic [WORD_W-1:0]         word_t;
  typedef logic [$clog2(CH_NUM)-1:0] ch_idx_t;
  typedef logic [CH_NUM-1:0]         ch_mask_t;

  localparam word_t ELEM_BYTES     = 32'd4;  // 32-bit elements only
  localparam word_t DMA_START_ADDR = 32'h0003_0000;
  localparam word_t DMA_CH_SIZE    = 32'h0000_0100;

  // DMA channel register offsets, listed in load order
  typedef enum logic [WORD_W-1:0] {
    DIMENSIONALITY = 32'h34,
    TOP_PAD        = 32'h3C,
    BOTTOM_PAD     = 32'h40,
    LEFT_PAD       = 32'h48,
    RIGHT_PAD      = 32'h44,
    SRC_PTR        = 32'h00,
    DST_PTR        = 32'h04,
    INC_SRC_D1     = 32'h18,
    INC_SRC_D2     = 32'h1C,
    INC_DST_D1     = 32'h20,
    INC_DST_D2     = 32'h24,
    SIZE_D2        = 32'h10,
    SIZE_D1        = 32'h0C
  } dma_reg_e;

  // One 2D transfer, in elements except for the pointers
  typedef struct packed {
    word_t in_ptr;
    word_t out_ptr;
    word_t inc_src_d2;
    word_t zeros_top;
    word_t zeros_bottom;
    word_t zeros_left;
    word_t zeros_right;
    word_t size_d1;
    word_t size_d2;
  } dma_txn_t;

  typedef enum logic [2:0] {
    P_IDLE,
    P_LIMIT,    // Limit offsets
    P_COORD,    // Image coordinates
    P_ZEROS,    // Pad counts
    P_RUN1,     // Sizes and source index
    P_RUN2,     // Pointer, waits for FIFO room
    P_PUSH,
    P_ADVANCE
  } param_state_e;

  typedef enum logic [3:0] {
    LD_IDLE,
    LD_CLAIM,
    LD_DIM,
    LD_TOP_PAD,
    LD_BOTTOM_PAD,
    LD_LEFT_PAD,
    LD_RIGHT_PAD,
    LD_SRC_PTR,
    LD_DST_PTR,
    LD_INC_SRC_D1,
    LD_INC_SRC_D2,
    LD_INC_DST_D1,
    LD_INC_DST_D2,
    LD_SIZE_D2,
    LD_SIZE_D1,
    LD_POP
  } load_state_e;

endpackage

// ==== design/im2col_top.sv ====
`timescale 1ns/1ps

module im2col_top
  import im2col_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  logic [DIM_W-1:0]    iw_i,
  input  logic [DIM_W-1:0]    ih_i,
  input  logic [DIM_W-1:0]    num_ch_i,
  input  logic [DIM_W-1:0]    fw_i,
  input  logic [DIM_W-1:0]    fh_i,
  input  logic [STRIDE_W-1:0] stride_d1_i,
  input  logic [STRIDE_W-1:0] stride_d2_i,
  input  logic [PAD_W-1:0]    pad_top_i,
  input  logic [PAD_W-1:0]    pad_bottom_i,
  input  logic [PAD_W-1:0]    pad_left_i,
  input  logic [PAD_W-1:0]    pad_right_i,
  input  logic [DIM_W-1:0]    n_patches_w_i,
  input  logic [DIM_W-1:0]    n_patches_h_i,
  input  word_t               src_ptr_i,
  input  word_t               dst_ptr_i,
  input  ch_mask_t            ch_mask_i,
  input  logic                irq_en_i,
  input  logic                irq_clr_i,
  output logic                bus_req_o,
  output word_t               bus_addr_o,
  output word_t               bus_wdata_o,
  input  logic                bus_rvalid_i,
  input  ch_mask_t            dma_done_i,
  output logic                done_o,
  output logic                irq_o
);

  logic     push, pop, fifo_full, fifo_empty;
  dma_txn_t push_txn, head_txn;
  logic     last_pushed, loader_idle;
  logic     claim, any_free, first_use, all_idle;
  ch_idx_t  free_ch;
  logic     run_end;
  logic     done_q, irq_q;

  im2col_param_unit u_param (
    .clk_i,
    .rst_ni,
    .start_i,
    .iw_i,
    .ih_i,
    .num_ch_i,
    .fw_i,
    .fh_i,
    .stride_d1_i,
    .stride_d2_i,
    .pad_top_i,
    .pad_bottom_i,
    .pad_left_i,
    .pad_right_i,
    .n_patches_w_i,
    .n_patches_h_i,
    .src_ptr_i,
    .dst_ptr_i,
    .fifo_full_i   (fifo_full),
    .push_o        (push),
    .txn_o         (push_txn),
    .last_pushed_o (last_pushed)
  );

  im2col_txn_fifo u_fifo (
    .clk_i,
    .rst_ni,
    .push_i  (push),
    .data_i  (push_txn),
    .pop_i   (pop),
    .data_o  (head_txn),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  im2col_channel_tracker u_tracker (
    .clk_i,
    .rst_ni,
    .start_i,
    .ch_mask_i,
    .dma_done_i,
    .claim_i     (claim),
    .free_ch_o   (free_ch),
    .any_free_o  (any_free),
    .first_use_o (first_use),
    .all_idle_o  (all_idle)
  );

  im2col_dma_loader u_loader (
    .clk_i,
    .rst_ni,
    .fifo_empty_i (fifo_empty),
    .txn_i        (head_txn),
    .stride_d1_i,
    .any_free_i   (any_free),
    .free_ch_i    (free_ch),
    .first_use_i  (first_use),
    .bus_rvalid_i,
    .fifo_pop_o   (pop),
    .claim_o      (claim),
    .bus_req_o,
    .bus_addr_o,
    .bus_wdata_o,
    .idle_o       (loader_idle)
  );

  // Everything computed, loaded and transferred
  assign run_end = last_pushed && fifo_empty && loader_idle && all_idle;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
      irq_q  <= 1'b0;
    end else begin
      if (start_i) begin
        done_q <= 1'b0;
      end else if (run_end) begin
        done_q <= 1'b1;
      end
      if (run_end && !done_q && !start_i && irq_en_i) begin
        irq_q <= 1'b1;  // Only on the rising edge of done
      end else if (irq_clr_i) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign done_o = done_q;
  assign irq_o  = irq_q;

endmodule

// ==== design/im2col_txn_fifo.sv ====
`timescale 1ns/1ps

module im2col_txn_fifo
  import im2col_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  dma_txn_t data_i,
  input  logic     pop_i,
  output dma_txn_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr_q, rd_ptr_q;
  logic [$clog2(FIFO_DEPTH):0]   count_q;
  logic                          do_push, do_pop;
  dma_txn_t                      mem_q [FIFO_DEPTH];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o  = mem_q[rd_ptr_q];  // Head shown without a pop
  assign full_o  = (count_q == FIFO_DEPTH);
  assign empty_o = (count_q == '0);

endmodule

// ==== dv/im2col_patterns.txt ====
# config: iw ih num_ch fw fh s1 s2 pad_t pad_b pad_l pad_r npw nph src dst mask irq_en (hex)
# descriptor: in_ptr out_ptr inc_src_d2 zeros_t zeros_b zeros_l zeros_r size_d1 size_d2 (hex)
4 4 1 3 3 1 1 1 1 1 1 4 4 1000 8000 f 1
1000 8000 2 1 0 1 0 3 3
1000 8040 1 1 0 0 0 4 3
1004 8080 2 1 0 0 1 3 3
1000 80c0 2 0 0 1 0 3 4
1000 8100 1 0 0 0 0 4 4
1004 8140 2 0 0 0 1 3 4
1010 8180 2 0 1 1 0 3 3
1010 81c0 1 0 1 0 0 4 3
1014 8200 2 0 1 0 1 3 3
4 4 2 2 2 2 2 0 0 0 0 2 2 2000 9000 3 0
2000 9000 6 0 0 0 0 2 2
2004 9010 6 0 0 0 0 2 2
2010 9020 6 0 0 0 0 2 2
2014 9030 6 0 0 0 0 2 2
2040 9040 6 0 0 0 0 2 2
2044 9050 6 0 0 0 0 2 2
2050 9060 6 0 0 0 0 2 2
2054 9070 6 0 0 0 0 2 2
3 2 2 2 1 1 1 0 0 0 0 2 2 3000 a000 5 1
3000 a000 2 0 0 0 0 2 2
3004 a010 2 0 0 0 0 2 2
3018 a020 2 0 0 0 0 2 2
301c a030 2 0 0 0 0 2 2

// ==== dv/im2col_tb.sv ====
`timescale 1ns/1ps

module im2col_tb
  import im2col_pkg::*;
;

  logic                clk_i;
  logic                rst_ni;
  logic                start_i;
  logic [DIM_W-1:0]    iw_i, ih_i, num_ch_i, fw_i, fh_i;
  logic [STRIDE_W-1:0] stride_d1_i, stride_d2_i;
  logic [PAD_W-1:0]    pad_top_i, pad_bottom_i, pad_left_i, pad_right_i;
  logic [DIM_W-1:0]    n_patches_w_i, n_patches_h_i;
  word_t               src_ptr_i, dst_ptr_i;
  ch_mask_t            ch_mask_i;
  logic                irq_en_i, irq_clr_i;
  logic                bus_req_o, bus_rvalid_i;
  word_t               bus_addr_o, bus_wdata_o;
  ch_mask_t            dma_done_i;
  logic                done_o, irq_o;

  word_t    cfg [3][17];      // One configuration per run
  word_t    dsc [64][9];      // Expected descriptors, all runs
  int       run_first [3];
  int       run_n [3];
  int       errors, checks, cycles, limit;
  word_t    rng;
  int       rsp_wait;
  int       done_wait [CH_NUM];
  ch_mask_t busy_m;           // Channels with a transfer in flight
  ch_mask_t pulse;
  ch_mask_t used;
  word_t    cur_s1;
  word_t    wr_addr [$];
  word_t    wr_data [$];
  logic     wr_busy [$];

  im2col_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic word_t xorshift(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic ch_idx_t ch_of(input word_t addr);
    word_t off;
    off = addr - DMA_START_ADDR;
    return off[9:8];
  endfunction

  function automatic word_t reg_of(input word_t addr);
    return {24'd0, addr[7:0]};
  endfunction

  // Bus slave and DMA channel model
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      bus_rvalid_i <= 1'b0;
      dma_done_i   <= '0;
      rsp_wait     <= 0;
      busy_m       <= '0;
      for (int i = 0; i < CH_NUM; i++) done_wait[i] <= 0;
    end else begin
      bus_rvalid_i <= (rsp_wait == 1);
      if (rsp_wait > 0) rsp_wait <= rsp_wait - 1;
      pulse = '0;
      for (int i = 0; i < CH_NUM; i++) begin
        if (done_wait[i] == 1) begin
          pulse[i] = 1'b1;
          busy_m[i] <= 1'b0;
        end
        if (done_wait[i] > 0) done_wait[i] <= done_wait[i] - 1;
      end
      dma_done_i <= pulse;
      if (bus_req_o) begin
        rng = xorshift(rng);
        bus_rvalid_i <= (rng % 3 == 0);  // Answer in the next cycle
        rsp_wait <= int'(rng % 3);       // Otherwise 2 or 3 cycles
        wr_addr.push_back(bus_addr_o);
        wr_data.push_back(bus_wdata_o);
        wr_busy.push_back(busy_m[ch_of(bus_addr_o)]);
        if (reg_of(bus_addr_o) == word_t'(SIZE_D1)) begin
          rng = xorshift(rng);
          done_wait[ch_of(bus_addr_o)] <= 5 + int'(rng % 16);
          busy_m[ch_of(bus_addr_o)] <= 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("Something failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_ch(input string name, input ch_idx_t got, input ch_idx_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s got %h exp %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic get_write(output word_t a, output word_t v, output logic b);
    while (wr_addr.size() == 0) @(negedge clk_i);
    a = wr_addr.pop_front();
    v = wr_data.pop_front();
    b = wr_busy.pop_front();
  endtask

  // One descriptor: 12 writes, or 13 on a channel's first load
  task automatic check_desc(input int d);
    word_t   exp_off [13];
    word_t   exp_dat [13];
    word_t   a, v;
    logic    b;
    ch_idx_t ch;
    int      first;
    get_write(a, v, b);
    ch = ch_of(a);
    if (!ch_mask_i[ch]) begin
      $display("channel %0d was loaded although it is disabled", ch);
      errors++;
    end
    if (b) begin
      $display("channel %0d was loaded while its transfer still ran", ch);
      errors++;
    end
    exp_off = '{word_t'(DIMENSIONALITY), word_t'(TOP_PAD), word_t'(BOTTOM_PAD),
                word_t'(LEFT_PAD), word_t'(RIGHT_PAD), word_t'(SRC_PTR), word_t'(DST_PTR),
                word_t'(INC_SRC_D1), word_t'(INC_SRC_D2), word_t'(INC_DST_D1),
                word_t'(INC_DST_D2), word_t'(SIZE_D2), word_t'(SIZE_D1)};
    exp_dat = '{32'd1, dsc[d][3] * 4, dsc[d][4] * 4, dsc[d][5] * 4, dsc[d][6] * 4,
                dsc[d][0], dsc[d][1], cur_s1 * 4, dsc[d][2] * 4, 32'd4, 32'd4,
                dsc[d][8] * 4, dsc[d][7] * 4};
    first = used[ch] ? 1 : 0;  // Dimensionality only once per channel
    used[ch] = 1'b1;
    for (int i = first; i < 13; i++) begin
      if (i != first) get_write(a, v, b);
      check_ch("channel", ch_of(a), ch);
      check_word("bus_addr", a, DMA_START_ADDR + DMA_CH_SIZE * word_t'(ch) + exp_off[i]);
      check_word("bus_wdata", v, exp_dat[i]);
    end
  endtask

  task automatic do_run(input int r);
    int err0;
    err0 = errors;
    @(posedge clk_i);
    iw_i <= cfg[r][0][DIM_W-1:0];
    ih_i <= cfg[r][1][DIM_W-1:0];
    num_ch_i <= cfg[r][2][DIM_W-1:0];
    fw_i <= cfg[r][3][DIM_W-1:0];
    fh_i <= cfg[r][4][DIM_W-1:0];
    stride_d1_i <= cfg[r][5][STRIDE_W-1:0];
    stride_d2_i <= cfg[r][6][STRIDE_W-1:0];
    pad_top_i <= cfg[r][7][PAD_W-1:0];
    pad_bottom_i <= cfg[r][8][PAD_W-1:0];
    pad_left_i <= cfg[r][9][PAD_W-1:0];
    pad_right_i <= cfg[r][10][PAD_W-1:0];
    n_patches_w_i <= cfg[r][11][DIM_W-1:0];
    n_patches_h_i <= cfg[r][12][DIM_W-1:0];
    src_ptr_i <= cfg[r][13];
    dst_ptr_i <= cfg[r][14];
    ch_mask_i <= cfg[r][15][CH_NUM-1:0];
    irq_en_i <= cfg[r][16][0];
    cur_s1 = cfg[r][5];
    used = '0;
    @(posedge clk_i);
    start_i <= 1'b1;
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
    check_flag("done_o", done_o, 1'b0);  // Cleared by start
    for (int d = 0; d < run_n[r]; d++) check_desc(run_first[r] + d);
    while (!done_o) @(negedge clk_i);
    check_flag("channels_idle", busy_m == '0, 1'b1);
    check_word("extra_writes", word_t'(wr_addr.size()), 32'd0);
    check_flag("irq_o", irq_o, cfg[r][16][0]);
    repeat (3) @(negedge clk_i);
    check_flag("done_o", done_o, 1'b1);
    @(posedge clk_i);
    irq_clr_i <= 1'b1;
    @(posedge clk_i);
    irq_clr_i <= 1'b0;
    @(negedge clk_i);
    check_flag("irq_o", irq_o, 1'b0);
    check_flag("done_o", done_o, 1'b1);  // Held until the next start
    $display("run %0d: %0d descriptors, %0d errors", r, run_n[r], errors - err0);
  endtask

  initial begin
    int    fd, n, total;
    string line;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 0;
    rng = 32'd43018;
    rst_ni = 1'b0;
    start_i = 1'b0;
    {iw_i, ih_i, num_ch_i, fw_i, fh_i} = '0;
    {stride_d1_i, stride_d2_i} = '0;
    {pad_top_i, pad_bottom_i, pad_left_i, pad_right_i} = '0;
    {n_patches_w_i, n_patches_h_i, src_ptr_i, dst_ptr_i} = '0;
    ch_mask_i = '0;
    irq_en_i = 1'b0;
    irq_clr_i = 1'b0;
    bus_rvalid_i = 1'b0;
    dma_done_i = '0;
    fd = $fopen("dv/im2col_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the patterns file");
      $display("Something failed");
      $finish;
    end else begin
      n = $fgets(line, fd);  // Two comment lines
      n = $fgets(line, fd);
      total = 0;
      for (int r = 0; r < 3; r++) begin
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    cfg[r][0], cfg[r][1], cfg[r][2], cfg[r][3], cfg[r][4], cfg[r][5],
                    cfg[r][6], cfg[r][7], cfg[r][8], cfg[r][9], cfg[r][10], cfg[r][11],
                    cfg[r][12], cfg[r][13], cfg[r][14], cfg[r][15], cfg[r][16]);
        if (n != 17) begin
          $display("configuration of run %0d in the patterns file is incomplete", r);
          errors++;
        end
        run_first[r] = total;
        run_n[r] = int'(cfg[r][2] * cfg[r][3] * cfg[r][4]);
        for (int d = total; d < total + run_n[r]; d++) begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", dsc[d][0], dsc[d][1], dsc[d][2],
                      dsc[d][3], dsc[d][4], dsc[d][5], dsc[d][6], dsc[d][7], dsc[d][8]);
          if (n != 9) begin
            $display("descriptor %0d in the patterns file is incomplete", d);
            errors++;
          end
        end
        total += run_n[r];
      end
      $fclose(fd);
      limit = 400 * total + 1000;
      repeat (5) @(posedge clk_i);
      rst_ni <= 1'b1;
      for (int r = 0; r < 3; r++) do_run(r);
      $display("runs 3, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
        $display("Everything OK");
      end else begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module im2col_tb -f all.f -o im2col_sim
./obj_dir/im2col_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  exit 1
fi
grep -q "Everything OK" sim.log
